/* sw_core.f */
hw/sw_seq_pkg.sv
hw/sw_score_pkg.sv
hw/sw_pe.sv
hw/sw_pe_array.sv
hw/sw_max_tracker.sv
hw/sw_ctrl.sv
hw/sw_core.sv
testbench/sw_core_assertions.sv
testbench/tb_sw_core.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat sw_core.f))

all: run

obj_dir/Vtb_sw_core: sw_core.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_sw_core -f sw_core.f -o Vtb_sw_core

run: obj_dir/Vtb_sw_core
	obj_dir/Vtb_sw_core | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* testbench/tb_sw_core.sv */
module tb_sw_core
  import sw_seq_pkg::*, sw_score_pkg::*;
();

  localparam int N_RANDOM  = 40;
  localparam int N_IDENT   = MAX_READ_LEN;
  localparam int N_MISS    = 8;
  localparam int N_JOBS    = N_RANDOM + N_IDENT + N_MISS;
  localparam int HOLD_MAX  = 7;
  localparam int LAT_BOUND = 2 * MAX_READ_LEN + MAX_REF_LEN + 2 + 2;
  localparam int CYCLE_LIMIT = 16 + 8 + N_JOBS * (LAT_BOUND + HOLD_MAX + 3 + 6) + 100;

  localparam int MATCH_I    = int'(MATCH_SCORE);
  localparam int MISMATCH_I = int'(MISMATCH_SCORE);
  localparam int OPEN_I     = int'(GAP_OPEN);
  localparam int EXTEND_I   = int'(GAP_EXTEND);

  logic                  clk;
  logic                  rst;
  logic                  i_valid;
  logic                  i_ready;
  logic [REF_W-1:0]      i_sequence_ref;
  logic [READ_W-1:0]     i_sequence_read;
  logic [REF_LEN_W-1:0]  i_seq_ref_length;
  logic [READ_LEN_W-1:0] i_seq_read_length;
  logic                  o_ready;
  logic                  o_valid;
  score_t                o_alignment_score;
  logic [ROW_W-1:0]      o_row;
  logic [COL_W-1:0]      o_column;

  logic [31:0] lfsr;
  int          cycle_count = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  // index 0 of the model matrices is the zero boundary
  int h_m [MAX_READ_LEN+1][MAX_REF_LEN+1];
  int i_m [MAX_READ_LEN+1][MAX_REF_LEN+1];
  int d_m [MAX_READ_LEN+1][MAX_REF_LEN+1];

  sw_core uut (
    .clk               (clk),
    .rst               (rst),
    .o_ready           (o_ready),
    .i_valid           (i_valid),
    .i_sequence_ref    (i_sequence_ref),
    .i_sequence_read   (i_sequence_read),
    .i_seq_ref_length  (i_seq_ref_length),
    .i_seq_read_length (i_seq_read_length),
    .i_ready           (i_ready),
    .o_valid           (o_valid),
    .o_alignment_score (o_alignment_score),
    .o_row             (o_row),
    .o_column          (o_column)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic int max2(input int a, input int b);
    return (b > a) ? b : a;
  endfunction

  // affine-gap smith-waterman with a row-major scan where strictly greater wins
  task automatic model_align(input logic [REF_W-1:0] rseq, input logic [READ_W-1:0] qseq,
                             input int rlen, input int qlen,
                             output int score, output int row, output int col);
    base_t rb;
    base_t qb;
    int    s;
    for (int r = 0; r <= MAX_READ_LEN; r++)
    begin
      for (int c = 0; c <= MAX_REF_LEN; c++)
      begin
        h_m[r][c] = 0;
        i_m[r][c] = 0;
        d_m[r][c] = 0;
      end
    end
    score = 0;
    row   = 0;
    col   = 0;
    for (int r = 1; r <= qlen; r++)
    begin
      for (int c = 1; c <= rlen; c++)
      begin
        qb = qseq[READ_W-2*r +: 2];  // first base in the msbs
        rb = rseq[REF_W-2*c +: 2];
        s  = (qb == rb) ? MATCH_I : MISMATCH_I;
        i_m[r][c] = max2(max2(h_m[r-1][c] + OPEN_I, i_m[r-1][c] + EXTEND_I), 0);
        d_m[r][c] = max2(max2(h_m[r][c-1] + OPEN_I, d_m[r][c-1] + EXTEND_I), 0);
        h_m[r][c] = max2(max2(h_m[r-1][c-1] + s, i_m[r][c]), max2(d_m[r][c], 0));
        if (h_m[r][c] > score)
        begin
          score = h_m[r][c];
          row   = r - 1;
          col   = c - 1;
        end
      end
    end
  endtask

  task automatic compare_field(input string name, input int got, input int expected);
    if (got != expected)
    begin
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, expected);
      errors++;
    end
  endtask

  task automatic run_job(input string kind, input logic [REF_W-1:0] rseq,
                         input logic [READ_W-1:0] qseq, input int rlen, input int qlen,
                         input int exp_score, input int exp_row, input int exp_col);
    int               lat;
    int               hold;
    int               err_before;
    logic [31:0]      v;
    score_t           held_score;
    logic [ROW_W-1:0] held_row;
    logic [COL_W-1:0] held_col;

    err_before = errors;
    @(negedge clk);
    while (!o_ready)
      @(negedge clk);
    i_valid           = 1'b1;
    i_sequence_ref    = rseq;
    i_sequence_read   = qseq;
    i_seq_ref_length  = REF_LEN_W'(rlen);
    i_seq_read_length = READ_LEN_W'(qlen);
    @(negedge clk);  // accepted on the edge just passed
    i_valid = 1'b0;
    lat = 0;
    while (!o_valid)
    begin
      @(negedge clk);
      lat++;
    end
    if (lat > 2 * qlen + rlen + 2 + 2)
    begin
      $display("o_valid came %0d cycles after accept, more than %0d allowed",
               lat, 2 * qlen + rlen + 4);
      errors++;
    end
    compare_field("o_alignment_score", o_alignment_score, exp_score);
    compare_field("o_row", o_row, exp_row);
    compare_field("o_column", o_column, exp_col);

    // result must stay put while the consumer stalls
    held_score = o_alignment_score;
    held_row   = o_row;
    held_col   = o_column;
    take_bits(3, v);
    hold = int'(v[2:0]);
    repeat (hold)
    begin
      @(negedge clk);
      if (!o_valid)
      begin
        $display("o_valid dropped while i_ready was low");
        errors++;
      end
      compare_field("o_alignment_score", o_alignment_score, held_score);
      compare_field("o_row", o_row, held_row);
      compare_field("o_column", o_column, held_col);
    end
    i_ready = 1'b1;
    @(negedge clk);
    i_ready = 1'b0;
    if (o_valid || !o_ready)
    begin
      $display("DUT did not return to idle after the result handshake");
      errors++;
    end

    tests_run++;
    if (errors == err_before)
      $display("test %0d %s ref=%0d read=%0d score=%0d row=%0d col=%0d lat=%0d ok",
               tests_run, kind, rlen, qlen, exp_score, exp_row, exp_col, lat);
    else
    begin
      tests_failed++;
      $display("test %0d %s ref=%0d read=%0d failed", tests_run, kind, rlen, qlen);
    end

    // short random pause, often none, so jobs also come back to back
    take_bits(2, v);
    repeat (int'(v[1:0]))
      @(negedge clk);
  endtask

  initial
  begin
    logic [31:0]       v;
    logic [REF_W-1:0]  rseq;
    logic [READ_W-1:0] qseq;
    int                rlen;
    int                qlen;
    int                es;
    int                er;
    int                ec;

    lfsr              = 32'hd036422e;
    rst               = 1'b1;
    i_valid           = 1'b0;
    i_ready           = 1'b0;
    i_sequence_ref    = '0;
    i_sequence_read   = '0;
    i_seq_ref_length  = '0;
    i_seq_read_length = '0;
    repeat (16)
      @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    tests_run++;
    if (!o_ready || o_valid)
    begin
      $display("after reset o_ready=%0b o_valid=%0b, expected 1 and 0", o_ready, o_valid);
      errors++;
      tests_failed++;
    end
    else
      $display("test %0d reset ok", tests_run);

    for (int n = 0; n < N_RANDOM; n++)
    begin
      take_bits(32, v);
      rseq = REF_W'(v);
      take_bits(32, v);
      qseq = READ_W'(v);
      take_bits(4, v);
      rlen = int'(v[3:0]) + 1;
      take_bits(4, v);
      qlen = int'(v[3:0]) + 1;
      model_align(rseq, qseq, rlen, qlen, es, er, ec);
      run_job("random", rseq, qseq, rlen, qlen, es, er, ec);
    end

    // same bases on both sides give a full diagonal match
    for (int len = 1; len <= N_IDENT; len++)
    begin
      take_bits(32, v);
      run_job("identical", REF_W'(v), READ_W'(v), len, len, len, len - 1, len - 1);
    end

    // ref bases in {0,1} against read bases in {2,3}
    for (int n = 0; n < N_MISS; n++)
    begin
      take_bits(32, v);
      rseq = REF_W'(v & 32'h5555_5555);
      take_bits(32, v);
      qseq = READ_W'(v | 32'haaaa_aaaa);
      take_bits(4, v);
      rlen = int'(v[3:0]) + 1;
      take_bits(4, v);
      qlen = int'(v[3:0]) + 1;
      run_job("mismatch", rseq, qseq, rlen, qlen, 0, 0, 0);
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* testbench/sw_core_assertions.sv */
module sw_core_assertions
  import sw_seq_pkg::*, sw_score_pkg::*;
(
  input logic             clk,
  input logic             rst,
  input logic             i_ready,
  input logic             o_ready,
  input logic             o_valid,
  input score_t           o_alignment_score,
  input logic [ROW_W-1:0] o_row,
  input logic [COL_W-1:0] o_column
);

  // result waits for the consumer
  a_result_held: assert property (@(posedge clk) disable iff (rst)
    o_valid && !i_ready |=> o_valid && $stable(o_row) && $stable(o_column)
      && $stable(o_alignment_score))
    else $error("result dropped or changed before i_ready");

  a_ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
    !(o_ready && o_valid))
    else $error("o_ready and o_valid high together");

  a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> o_ready)
    else $error("o_ready low right after reset release");

endmodule

bind sw_core sw_core_assertions u_assertions (
  .clk               (clk),
  .rst               (rst),
  .i_ready           (i_ready),
  .o_ready           (o_ready),
  .o_valid           (o_valid),
  .o_alignment_score (o_alignment_score),
  .o_row             (o_row),
  .o_column          (o_column)
);

/* hw/sw_core.sv */
module sw_core
  import sw_seq_pkg::*, sw_score_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  output logic                  o_ready,
  input  logic                  i_valid,
  input  logic [REF_W-1:0]      i_sequence_ref,
  input  logic [READ_W-1:0]     i_sequence_read,
  input  logic [REF_LEN_W-1:0]  i_seq_ref_length,   // 1-based
  input  logic [READ_LEN_W-1:0] i_seq_read_length,  // 1-based
  input  logic                  i_ready,
  output logic                  o_valid,
  output score_t                o_alignment_score,
  output logic [ROW_W-1:0]      o_row,
  output logic [COL_W-1:0]      o_column
);

  logic                      clear;
  logic                      calc_en;
  logic                      select_en;
  logic [CNT_W-1:0]          count;
  logic                      ref_valid;
  base_t                     ref_base;
  logic [READ_W-1:0]         read_seq;
  score_t [MAX_READ_LEN-1:0] best_scores;

  sw_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (i_valid),
    .i_ready     (i_ready),
    .i_seq_ref   (i_sequence_ref),
    .i_seq_read  (i_sequence_read),
    .i_ref_len   (i_seq_ref_length),
    .i_read_len  (i_seq_read_length),
    .o_ready     (o_ready),
    .o_valid     (o_valid),
    .o_clear     (clear),
    .o_calc_en   (calc_en),
    .o_select_en (select_en),
    .o_count     (count),
    .o_ref_valid (ref_valid),
    .o_ref_base  (ref_base),
    .o_read_seq  (read_seq)
  );

  // one element per read base, reference streams through
  sw_pe_array u_array (
    .clk           (clk),
    .rst           (rst),
    .i_clear       (clear),
    .i_calc_en     (calc_en),
    .i_ref_valid   (ref_valid),
    .i_ref_base    (ref_base),
    .i_read_seq    (read_seq),
    .o_best_scores (best_scores)
  );

  sw_max_tracker u_tracker (
    .clk           (clk),
    .rst           (rst),
    .i_clear       (clear),
    .i_calc_en     (calc_en),
    .i_select_en   (select_en),
    .i_count       (count),
    .i_best_scores (best_scores),
    .o_score       (o_alignment_score),
    .o_row         (o_row),
    .o_column      (o_column)
  );

endmodule

/* hw/sw_ctrl.sv */
module sw_ctrl
  import sw_seq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_valid,
  input  logic                  i_ready,
  input  logic [REF_W-1:0]      i_seq_ref,
  input  logic [READ_W-1:0]     i_seq_read,
  input  logic [REF_LEN_W-1:0]  i_ref_len,
  input  logic [READ_LEN_W-1:0] i_read_len,
  output logic                  o_ready,
  output logic                  o_valid,
  output logic                  o_clear,
  output logic                  o_calc_en,
  output logic                  o_select_en,
  output logic [CNT_W-1:0]      o_count,
  output logic                  o_ref_valid,
  output base_t                 o_ref_base,
  output logic [READ_W-1:0]     o_read_seq
);

  typedef enum logic [2:0] {S_IDLE, S_INPUT, S_CALC, S_SELECT, S_DONE} state_t;

  state_t                state;
  state_t                state_n;
  logic [CNT_W-1:0]      count;
  logic [REF_W-1:0]      ref_seq;
  logic [REF_W-1:0]      ref_shift;
  logic [READ_W-1:0]     read_seq;
  logic [REF_LEN_W-1:0]  ref_len;
  logic [READ_LEN_W-1:0] read_len;
  logic                  calc_last;
  logic                  select_last;

  assign calc_last   = count == CNT_W'(ref_len) + CNT_W'(read_len) - 1'b1;
  assign select_last = count == CNT_W'(read_len) - 1'b1;

  always_comb
  begin
    state_n = state;
    case (state)
      S_IDLE:   if (i_valid) state_n = S_INPUT;
      S_INPUT:  state_n = S_CALC;
      S_CALC:   if (calc_last) state_n = S_SELECT;
      S_SELECT: if (select_last) state_n = S_DONE;
      S_DONE:   if (i_ready) state_n = S_IDLE;
      default:  state_n = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= S_IDLE;
      count <= '0;
    end
    else
    begin
      state <= state_n;
      // counts columns in calc, rows in select
      if ((state == S_CALC && !calc_last) || (state == S_SELECT && !select_last))
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && i_valid)
    begin
      ref_seq  <= i_seq_ref;
      read_seq <= i_seq_read;
      ref_len  <= i_ref_len;
      read_len <= i_read_len;
    end
    if (state == S_INPUT)
      ref_shift <= ref_seq;
    else if (state == S_CALC)
      ref_shift <= ref_shift << $bits(base_t);  // one base per cycle
  end

  assign o_ready     = state == S_IDLE;
  assign o_valid     = state == S_DONE;
  assign o_clear     = state == S_IDLE;
  assign o_calc_en   = state == S_CALC;
  assign o_select_en = state == S_SELECT;
  assign o_count     = count;
  assign o_ref_valid = (state == S_CALC) && (count < CNT_W'(ref_len));
  assign o_ref_base  = ref_shift[REF_W-1 -: $bits(base_t)];
  assign o_read_seq  = read_seq;

endmodule

/* hw/sw_max_tracker.sv */
module sw_max_tracker
  import sw_seq_pkg::*, sw_score_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_clear,
  input  logic                      i_calc_en,
  input  logic                      i_select_en,
  input  logic [CNT_W-1:0]          i_count,
  input  score_t [MAX_READ_LEN-1:0] i_best_scores,
  output score_t                    o_score,
  output logic [ROW_W-1:0]          o_row,
  output logic [COL_W-1:0]          o_column
);

  score_t           row_max [MAX_READ_LEN];
  logic [COL_W-1:0] row_col [MAX_READ_LEN];
  logic [ROW_W-1:0] sel_row;

  assign sel_row = i_count[ROW_W-1:0];  // select phase counts rows

  // per-row maximum, scores arrive one cycle after the cell
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      row_max <= '{default: '0};
      row_col <= '{default: '0};
    end
    else if (i_clear)
    begin
      row_max <= '{default: '0};
      row_col <= '{default: '0};
    end
    else if (i_calc_en)
    begin
      for (int r = 0; r < MAX_READ_LEN; r++)
      begin
        if (i_best_scores[r] > row_max[r])
        begin
          row_max[r] <= i_best_scores[r];
          row_col[r] <= COL_W'(i_count - r - 1);
        end
      end
    end
  end

  // sweep rows from 0, strictly greater wins
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      o_score  <= '0;
      o_row    <= '0;
      o_column <= '0;
    end
    else if (i_clear)
    begin
      o_score  <= '0;
      o_row    <= '0;
      o_column <= '0;
    end
    else if (i_select_en && row_max[sel_row] > o_score)
    begin
      o_score  <= row_max[sel_row];
      o_row    <= sel_row;
      o_column <= row_col[sel_row];
    end
  end

endmodule

/* hw/sw_pe_array.sv */
module sw_pe_array
  import sw_seq_pkg::*, sw_score_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_clear,
  input  logic                      i_calc_en,
  input  logic                      i_ref_valid,
  input  base_t                     i_ref_base,
  input  logic [READ_W-1:0]         i_read_seq,
  output score_t [MAX_READ_LEN-1:0] o_best_scores
);

  // combinational cell scores of the current cycle
  score_t h_now   [MAX_READ_LEN];
  score_t ins_now [MAX_READ_LEN];
  score_t del_now [MAX_READ_LEN];

  // one cycle back gives own left and the next row's top
  score_t h_q1    [MAX_READ_LEN];
  score_t ins_q1  [MAX_READ_LEN];
  score_t del_q1  [MAX_READ_LEN];

  // two cycles back gives the next row's diagonal
  score_t h_q2    [MAX_READ_LEN];
  score_t ins_q2  [MAX_READ_LEN];
  score_t del_q2  [MAX_READ_LEN];

  logic   ref_valid_chain [MAX_READ_LEN+1];
  base_t  ref_base_chain  [MAX_READ_LEN+1];

  assign ref_valid_chain[0] = i_ref_valid;
  assign ref_base_chain[0]  = i_ref_base;

  genvar k;
  generate
    for (k = 0; k < MAX_READ_LEN; k++)
    begin : g_pe
      score_t h_top;
      score_t ins_top;
      score_t h_diag;
      score_t ins_diag;
      score_t del_diag;

      if (k == 0)
      begin : g_edge
        // zero boundary above the first row
        assign h_top    = '0;
        assign ins_top  = '0;
        assign h_diag   = '0;
        assign ins_diag = '0;
        assign del_diag = '0;
      end
      else
      begin : g_inner
        assign h_top    = h_q1[k-1];
        assign ins_top  = ins_q1[k-1];
        assign h_diag   = h_q2[k-1];
        assign ins_diag = ins_q2[k-1];
        assign del_diag = del_q2[k-1];
      end

      sw_pe u_pe (
        .clk          (clk),
        .rst          (rst),
        .i_ref_valid  (ref_valid_chain[k] && !i_clear),  // idle flushes the last job's bases
        .i_read_valid (1'b1),
        .i_ref_base   (ref_base_chain[k]),
        .i_read_base  (i_read_seq[READ_W-1-$bits(base_t)*k -: $bits(base_t)]),
        .i_h_diag     (h_diag),
        .i_h_top      (h_top),
        .i_h_left     (h_q1[k]),
        .i_i_diag     (ins_diag),
        .i_i_top      (ins_top),
        .i_i_left     (ins_q1[k]),
        .i_d_diag     (del_diag),
        .i_d_left     (del_q1[k]),
        .o_h          (h_now[k]),
        .o_i          (ins_now[k]),
        .o_d          (del_now[k]),
        .o_best       (o_best_scores[k]),
        .o_ref_valid  (ref_valid_chain[k+1]),
        .o_ref_base   (ref_base_chain[k+1])
      );
    end
  endgenerate

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      h_q1   <= '{default: '0};
      ins_q1 <= '{default: '0};
      del_q1 <= '{default: '0};
      h_q2   <= '{default: '0};
      ins_q2 <= '{default: '0};
      del_q2 <= '{default: '0};
    end
    else if (i_clear)
    begin
      h_q1   <= '{default: '0};
      ins_q1 <= '{default: '0};
      del_q1 <= '{default: '0};
      h_q2   <= '{default: '0};
      ins_q2 <= '{default: '0};
      del_q2 <= '{default: '0};
    end
    else if (i_calc_en)
    begin
      h_q1   <= h_now;
      ins_q1 <= ins_now;
      del_q1 <= del_now;
      h_q2   <= h_q1;
      ins_q2 <= ins_q1;
      del_q2 <= del_q1;
    end
  end

endmodule

/* hw/sw_pe.sv */
module sw_pe
  import sw_seq_pkg::*, sw_score_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   i_ref_valid,
  input  logic   i_read_valid,
  input  base_t  i_ref_base,
  input  base_t  i_read_base,
  input  score_t i_h_diag,
  input  score_t i_h_top,
  input  score_t i_h_left,
  input  score_t i_i_diag,
  input  score_t i_i_top,
  input  score_t i_i_left,
  input  score_t i_d_diag,
  input  score_t i_d_left,
  output score_t o_h,
  output score_t o_i,
  output score_t o_d,
  output score_t o_best,
  output logic   o_ref_valid,
  output base_t  o_ref_base
);

  function automatic score_t larger(input score_t a, input score_t b);
    return (b > a) ? b : a;
  endfunction

  logic   cell_en;
  score_t sub_score;
  score_t ins_cell;
  score_t del_cell;
  score_t diag_cell;
  score_t h_cell;
  score_t best_w;

  assign cell_en   = i_ref_valid && i_read_valid;
  assign sub_score = (i_ref_base == i_read_base) ? MATCH_SCORE : MISMATCH_SCORE;

  always_comb
  begin
    ins_cell  = larger(larger(i_h_top + GAP_OPEN, i_i_top + GAP_EXTEND), '0);
    del_cell  = larger(larger(i_h_left + GAP_OPEN, i_d_left + GAP_EXTEND), '0);
    // h never drops below i or d, so this reduces to h_diag + s
    diag_cell = larger(larger(i_h_diag, i_i_diag), i_d_diag) + sub_score;
    if (diag_cell >= ins_cell && diag_cell >= del_cell)
      h_cell = diag_cell;
    else if (ins_cell >= del_cell)
      h_cell = ins_cell;
    else
      h_cell = del_cell;
    h_cell = larger(h_cell, '0);
  end

  // idle slot keeps the row's last column
  assign o_h = cell_en ? h_cell   : i_h_left;
  assign o_i = cell_en ? ins_cell : i_i_left;
  assign o_d = cell_en ? del_cell : i_d_left;

  assign best_w = larger(larger(larger(o_h, o_i), o_d), '0);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      o_ref_valid <= 1'b0;
    else
      o_ref_valid <= i_ref_valid;
  end

  always_ff @(posedge clk)
  begin
    o_ref_base <= i_ref_base;  // next element down the chain
    o_best     <= best_w;
  end

endmodule

/* hw/sw_score_pkg.sv */
package sw_score_pkg;

  localparam int SCORE_W = 10;

  typedef logic signed [SCORE_W-1:0] score_t;

  // affine gap scoring
  localparam score_t MATCH_SCORE    = score_t'(1);
  localparam score_t MISMATCH_SCORE = score_t'(-4);
  localparam score_t GAP_OPEN       = score_t'(-6);
  localparam score_t GAP_EXTEND     = score_t'(-1);

endpackage

/* hw/sw_seq_pkg.sv */
package sw_seq_pkg;

  // two-bit base code, first base sits in the msbs of a sequence
  typedef logic [1:0] base_t;

  localparam int MAX_REF_LEN  = 16;
  localparam int MAX_READ_LEN = 16;

  localparam int REF_W  = $bits(base_t) * MAX_REF_LEN;
  localparam int READ_W = $bits(base_t) * MAX_READ_LEN;

  // 1-based lengths need one extra bit
  localparam int REF_LEN_W  = $clog2(MAX_REF_LEN) + 1;
  localparam int READ_LEN_W = $clog2(MAX_READ_LEN) + 1;

  localparam int COL_W = $clog2(MAX_REF_LEN);   // 0-based reference position
  localparam int ROW_W = $clog2(MAX_READ_LEN);  // 0-based read position

  // calculate phase runs up to ref + read cycles
  localparam int CNT_W = $clog2(MAX_REF_LEN + MAX_READ_LEN) + 1;

endpackage
